//--- src.f
design/arch_defs_pkg.sv
design/program_counter.sv
design/alu.sv
design/control_unit.sv
design/cpu.sv
design/ram.sv
design/cpu_system.sv
verification/clk_rst_gen.sv
verification/cpu_checker.sv
verification/tb_cpu_system.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then search the log for the fail message
verilator --binary --timing --top-module tb_cpu_system -f src.f -o sim_cpu \
    && ./obj_dir/sim_cpu > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -qF '*** FAILED ***' sim.log && exit 1 || exit 0

//--- verification/tb_cpu_system.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_system
    import arch_defs_pkg::*;
();

    localparam int NUM_TESTS   = 15;
    localparam int PROG_BYTES  = 2**ADDR_WIDTH;
    localparam int IMAGE_W     = DATA_WIDTH * PROG_BYTES;
    // Worst-case run time plus room for program loading
    localparam int WATCHDOG_NS = (NUM_TESTS * 16 * 4 + 16) * 10 + NUM_TESTS * 500;

    wire                   clk;
    wire                   por_n;
    wire                   dut_rst_n;
    logic                  test_rst_n;
    logic                  prog_we;
    logic [ADDR_WIDTH-1:0] prog_addr;
    logic [DATA_WIDTH-1:0] prog_data;
    wire  [DATA_WIDTH-1:0] out_data;
    wire                   out_valid;
    wire                   halt;
    wire                   flag_z;
    wire                   flag_c;
    wire                   flag_n;

    // Checker handshake
    logic                  check_start;
    logic [7:0]            test_idx;
    logic [DATA_WIDTH-1:0] exp_out;
    logic [FLAG_COUNT-1:0] exp_flags;
    wire                   check_done;
    int                    pass_count;
    int                    fail_count;

    // Test table, byte 0 of each image sits at the top
    logic [IMAGE_W-1:0]    prog_q[$];
    logic [DATA_WIDTH-1:0] exp_out_q[$];
    logic [FLAG_COUNT-1:0] exp_flags_q[$];
    logic [15:0]           lfsr_state;

    assign dut_rst_n = por_n & test_rst_n;

    clk_rst_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (16)
    ) u_clk_rst_gen (
        .clk_o   (clk),
        .rst_n_o (por_n)
    );

    cpu_system #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) dut_i (
        .clk             (clk),
        .arst_n_i        (dut_rst_n),
        .prog_we_i       (prog_we),
        .prog_addr_i     (prog_addr),
        .prog_data_i     (prog_data),
        .out_data_o      (out_data),
        .out_valid_o     (out_valid),
        .halt_o          (halt),
        .flag_zero_o     (flag_z),
        .flag_carry_o    (flag_c),
        .flag_negative_o (flag_n)
    );

    cpu_checker #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_cpu_checker (
        .clk_i           (clk),
        .start_i         (check_start),
        .test_idx_i      (test_idx),
        .exp_out_i       (exp_out),
        .exp_flags_i     (exp_flags),
        .out_data_i      (out_data),
        .out_valid_i     (out_valid),
        .halt_i          (halt),
        .flag_zero_i     (flag_z),
        .flag_carry_i    (flag_c),
        .flag_negative_i (flag_n),
        .done_o          (check_done),
        .pass_count_o    (pass_count),
        .fail_count_o    (fail_count)
    );

    // ================================================
    // Table, LFSR and per-test tasks
    // ================================================
    function automatic void add_test(input logic [IMAGE_W-1:0] image,
                                     input logic [DATA_WIDTH-1:0] out_v,
                                     input logic [FLAG_COUNT-1:0] flags_v);
        prog_q.push_back(image);
        exp_out_q.push_back(out_v);
        exp_flags_q.push_back(flags_v);
    endfunction

    // Galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic random_byte(output logic [DATA_WIDTH-1:0] value);
        value = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            value      = {value[DATA_WIDTH-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Write the whole image through the load port
    task automatic load_program(input logic [IMAGE_W-1:0] image);
        for (int i = 0; i < PROG_BYTES; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= ADDR_WIDTH'(i);
            prog_data <= image[DATA_WIDTH*(PROG_BYTES-1-i) +: DATA_WIDTH];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic run_test(input int t);
        @(posedge clk);
        test_rst_n <= 1'b0;
        test_idx   <= t[7:0];
        exp_out    <= exp_out_q[t];
        exp_flags  <= exp_flags_q[t];
        load_program(prog_q[t]);
        // Release the CPU and arm the checker on the same edge
        @(posedge clk);
        test_rst_n  <= 1'b1;
        check_start <= 1'b1;
        @(posedge clk);
        check_start <= 1'b0;
        do @(posedge clk); while (!check_done);
    endtask

    // ================================================
    // Main sequence
    // ================================================
    initial begin
        logic [DATA_WIDTH-1:0] op_x;
        logic [DATA_WIDTH-1:0] op_y;
        logic [DATA_WIDTH:0]   sum;
        test_rst_n  = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        check_start = 1'b0;
        test_idx    = '0;
        exp_out     = '0;
        exp_flags   = '0;
        lfsr_state  = 16'd69;

        // Flags column is {N, C, Z}
        add_test(128'h35E0F000_00000000_00000000_00000000, 8'h05, 3'b000);
        add_test(128'h30E0F000_00000000_00000000_00000000, 8'h00, 3'b001);
        add_test(128'h1E2F50E0_F0000000_00000000_0000C850, 8'h18, 3'b010);
        add_test(128'h1E2F60E0_F0000000_00000000_00003050, 8'hE0, 3'b100);
        add_test(128'h1E2F60E0_F0000000_00000000_00004242, 8'h00, 3'b011);
        add_test(128'h1E2F70E0_F0000000_00000000_0000F09C, 8'h90, 3'b100);
        add_test(128'h1E2F80E0_F0000000_00000000_00000F30, 8'h3F, 3'b000);
        // STA then LDA of address 13
        add_test(128'h394D301D_E0F00000_00000000_00000000, 8'h09, 3'b000);
        // Branches, the two paths print different values
        add_test(128'h30A531E0_F037E0F0_00000000_00000000, 8'h07, 3'b000);
        add_test(128'h33A531E0_F037E0F0_00000000_00000000, 8'h01, 3'b000);
        add_test(128'h1E2F50B7_E0F00032_E0F00000_00008080, 8'h02, 3'b000);
        add_test(128'h1EC5E0F0_0036E0F0_00000000_00008500, 8'h06, 3'b000);
        add_test(128'h1EC5E0F0_0036E0F0_00000000_00000500, 8'h05, 3'b000);
        add_test(128'h3494E0F0_3AE0F000_00000000_00000000, 8'h0A, 3'b000);

        // Random ADD operands, expected sum and flags from the ADD rule
        random_byte(op_x);
        random_byte(op_y);
        sum = {1'b0, op_x} + {1'b0, op_y};
        add_test({112'h1E2F50E0_F0000000_00000000_0000, op_x, op_y}, sum[DATA_WIDTH-1:0],
                 {sum[DATA_WIDTH-1], sum[DATA_WIDTH], sum[DATA_WIDTH-1:0] == '0});

        wait (por_n === 1'b1);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("tests %0d, passed %0d, failed %0d", NUM_TESTS, pass_count, fail_count);
        if (fail_count == 0 && pass_count == NUM_TESTS) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog in case a test never completes
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before all tests completed", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/cpu_checker.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_checker
    import arch_defs_pkg::*;
#(
    parameter int DATA_WIDTH    = arch_defs_pkg::DATA_WIDTH,
    parameter int HALT_LIMIT    = 80,
    parameter int SETTLE_CYCLES = 4
) (
    input  wire                   clk_i,
    // Expectations for the test that starts
    input  wire                   start_i,
    input  wire  [7:0]            test_idx_i,
    input  wire  [DATA_WIDTH-1:0] exp_out_i,
    input  wire  [FLAG_COUNT-1:0] exp_flags_i,
    // Observed DUT outputs
    input  wire  [DATA_WIDTH-1:0] out_data_i,
    input  wire                   out_valid_i,
    input  wire                   halt_i,
    input  wire                   flag_zero_i,
    input  wire                   flag_carry_i,
    input  wire                   flag_negative_i,
    // Results
    output logic                  done_o,
    output int                    pass_count_o,
    output int                    fail_count_o
);

    logic active;
    logic halted;
    int   cycles;
    int   settle;
    int   out_seen;
    int   test_errors;

    initial begin
        active       = 1'b0;
        halted       = 1'b0;
        done_o       = 1'b0;
        pass_count_o = 0;
        fail_count_o = 0;
    end

    // Wrong value, printed with the port name and both values in hex
    task automatic compare_value(input string name, input logic [DATA_WIDTH-1:0] exp_v,
                                 input logic [DATA_WIDTH-1:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERROR test %0d: %s expected 0x%h got 0x%h",
                     test_idx_i, name, exp_v, act_v);
            test_errors++;
        end
    endtask

    // One line per test, then hand control back
    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %0d: pass", test_idx_i);
            pass_count_o <= pass_count_o + 1;
        end else begin
            $display("test %0d: fail with %0d errors", test_idx_i, test_errors);
            fail_count_o <= fail_count_o + 1;
        end
        done_o <= 1'b1;
        active = 1'b0;
    endtask

    // ================================================
    // Monitor, sampled on the rising edge
    // ================================================
    always @(posedge clk_i) begin
        done_o <= 1'b0;
        if (start_i) begin
            active      = 1'b1;
            halted      = 1'b0;
            cycles      = 0;
            settle      = 0;
            out_seen    = 0;
            test_errors = 0;
        end else if (active) begin
            cycles++;
            // Only the first OUT strobe is expected
            if (out_valid_i) begin
                if (out_seen == 0) begin
                    compare_value("out_data_o", exp_out_i, out_data_i);
                end else begin
                    $display("test %0d: extra OUT strobe seen", test_idx_i);
                    test_errors++;
                end
                out_seen++;
            end
            if (halted) begin
                // Halt must hold while the window runs out
                if (!halt_i) begin
                    $display("test %0d: halt_o dropped after halting", test_idx_i);
                    test_errors++;
                end
                settle++;
                if (settle == SETTLE_CYCLES) begin
                    finish_test();
                end
            end else if (halt_i) begin
                halted = 1'b1;
                if (out_seen == 0) begin
                    $display("test %0d: halted without any OUT strobe", test_idx_i);
                    test_errors++;
                end
                compare_value("flag_zero_o", DATA_WIDTH'(exp_flags_i[FLAG_Z]),
                              DATA_WIDTH'(flag_zero_i));
                compare_value("flag_carry_o", DATA_WIDTH'(exp_flags_i[FLAG_C]),
                              DATA_WIDTH'(flag_carry_i));
                compare_value("flag_negative_o", DATA_WIDTH'(exp_flags_i[FLAG_N]),
                              DATA_WIDTH'(flag_negative_i));
            end else if (cycles > HALT_LIMIT) begin
                $display("test %0d: halt never arrived within %0d cycles",
                         test_idx_i, HALT_LIMIT);
                test_errors++;
                finish_test();
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/clk_rst_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clk_rst_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Free-running clock, low at time zero
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Power-on reset, released on a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- design/cpu_system.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_system
    import arch_defs_pkg::*;
#(
    parameter int DATA_WIDTH = arch_defs_pkg::DATA_WIDTH,
    parameter int ADDR_WIDTH = arch_defs_pkg::ADDR_WIDTH
) (
    input  wire                   clk,
    input  wire                   arst_n_i,
    // Program load, used while the CPU is held in reset
    input  wire                   prog_we_i,
    input  wire  [ADDR_WIDTH-1:0] prog_addr_i,
    input  wire  [DATA_WIDTH-1:0] prog_data_i,
    // OUT register
    output logic [DATA_WIDTH-1:0] out_data_o,
    output logic                  out_valid_o,
    // Status
    output logic                  halt_o,
    output logic                  flag_zero_o,
    output logic                  flag_carry_o,
    output logic                  flag_negative_o
);

    // CPU to RAM
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [DATA_WIDTH-1:0] mem_wdata, mem_rdata;
    logic                  mem_write;

    cpu #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_cpu (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .mem_addr_o      (mem_addr),
        .mem_data_i      (mem_rdata),
        .mem_write_o     (mem_write),
        .mem_data_o      (mem_wdata),
        .out_data_o      (out_data_o),
        .out_valid_o     (out_valid_o),
        .halt_o          (halt_o),
        .flag_zero_o     (flag_zero_o),
        .flag_carry_o    (flag_carry_o),
        .flag_negative_o (flag_negative_o)
    );

    ram #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .clk         (clk),
        .addr_i      (mem_addr),
        .we_i        (mem_write),
        .wdata_i     (mem_wdata),
        .rdata_o     (mem_rdata),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i)
    );

endmodule

`default_nettype wire

//--- design/ram.sv
`timescale 1ns/10ps
`default_nettype none

module ram
    import arch_defs_pkg::*;
#(
    parameter int DATA_WIDTH = arch_defs_pkg::DATA_WIDTH,
    parameter int ADDR_WIDTH = arch_defs_pkg::ADDR_WIDTH
) (
    input  wire                   clk,
    // CPU port
    input  wire  [ADDR_WIDTH-1:0] addr_i,
    input  wire                   we_i,
    input  wire  [DATA_WIDTH-1:0] wdata_i,
    output logic [DATA_WIDTH-1:0] rdata_o,
    // Program load port
    input  wire                   prog_we_i,
    input  wire  [ADDR_WIDTH-1:0] prog_addr_i,
    input  wire  [DATA_WIDTH-1:0] prog_data_i
);

    // Contents survive a CPU reset
    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // Program load beats a CPU store in the same cycle
    always_ff @(posedge clk) begin
        if (prog_we_i) begin
            mem[prog_addr_i] <= prog_data_i;
        end else if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // Combinational read
    assign rdata_o = mem[addr_i];

endmodule

`default_nettype wire

//--- design/cpu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu
    import arch_defs_pkg::*;
#(
    parameter int DATA_WIDTH = arch_defs_pkg::DATA_WIDTH,
    parameter int ADDR_WIDTH = arch_defs_pkg::ADDR_WIDTH
) (
    input  wire                   clk,
    input  wire                   arst_n_i,
    // Memory side
    output logic [ADDR_WIDTH-1:0] mem_addr_o,
    input  wire  [DATA_WIDTH-1:0] mem_data_i,
    output logic                  mem_write_o,
    output logic [DATA_WIDTH-1:0] mem_data_o,
    // Output register
    output logic [DATA_WIDTH-1:0] out_data_o,
    output logic                  out_valid_o,
    // Status
    output logic                  halt_o,
    output logic                  flag_zero_o,
    output logic                  flag_carry_o,
    output logic                  flag_negative_o
);

    // Control strobes
    logic load_a, load_b, load_ir, load_pc, load_mar;
    logic load_flags, load_sets_zn, pc_enable, out_load;
    logic oe_pc, oe_ram, oe_ir, oe_alu, oe_a;
    alu_op_e alu_op;
    ustep_t  ustep;

    // Datapath
    logic [DATA_WIDTH-1:0]    bus;
    logic [DATA_WIDTH-1:0]    a_reg, b_reg, ir_reg, alu_result;
    logic [ADDR_WIDTH-1:0]    pc;
    logic [OPERAND_WIDTH-1:0] operand;
    logic [DATA_WIDTH-1:0]    operand_ext;
    opcode_e                  opcode;

    // Flags
    logic [FLAG_COUNT-1:0] flags_reg, flags_d;
    logic                  alu_zero, alu_carry, alu_negative;

    // ================================================
    // Instruction decode
    // ================================================
    assign operand     = ir_reg[OPERAND_WIDTH-1:0];
    assign operand_ext = {{(DATA_WIDTH-OPERAND_WIDTH){1'b0}}, operand};

    // During the IR fetch step the opcode comes straight from RAM
    // so the control unit can end a NOP one cycle early
    assign opcode = (ustep == ustep_t'(1)) ?
                    opcode_e'(mem_data_i[DATA_WIDTH-1 -: OPCODE_WIDTH]) :
                    opcode_e'(ir_reg[DATA_WIDTH-1 -: OPCODE_WIDTH]);

    // ================================================
    // Shared bus
    // ================================================
    // Priority mux that carries zero when no enable is set
    always_comb begin
        if (oe_pc) begin
            bus = {{(DATA_WIDTH-ADDR_WIDTH){1'b0}}, pc};
        end else if (oe_ram) begin
            bus = mem_data_i;
        end else if (oe_ir) begin
            bus = operand_ext;
        end else if (oe_alu) begin
            bus = alu_result;
        end else if (oe_a) begin
            bus = a_reg;
        end else begin
            bus = '0;
        end
    end

    // ================================================
    // Registers
    // ================================================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            a_reg       <= '0;
            b_reg       <= '0;
            ir_reg      <= '0;
            mem_addr_o  <= '0;
            flags_reg   <= '0;
            out_data_o  <= '0;
            out_valid_o <= 1'b0;
        end else begin
            if (load_a)     a_reg      <= bus;
            if (load_b)     b_reg      <= bus;
            if (load_ir)    ir_reg     <= bus;
            if (load_mar)   mem_addr_o <= bus[ADDR_WIDTH-1:0];
            if (load_flags) flags_reg  <= flags_d;
            // OUT latches A and the strobe lands with the new value
            if (out_load)   out_data_o <= a_reg;
            out_valid_o <= out_load;
        end
    end

    // STA always writes A
    assign mem_data_o = a_reg;

    // Flag source is the loaded value or the ALU status
    // LDI puts the zero-extended operand on the bus, LDA and LDB the RAM word
    always_comb begin
        if (load_sets_zn) begin
            flags_d[FLAG_Z] = (bus == '0);
            flags_d[FLAG_C] = 1'b0;
            flags_d[FLAG_N] = bus[DATA_WIDTH-1];
        end else begin
            flags_d[FLAG_Z] = alu_zero;
            flags_d[FLAG_C] = alu_carry;
            flags_d[FLAG_N] = alu_negative;
        end
    end

    assign flag_zero_o     = flags_reg[FLAG_Z];
    assign flag_carry_o    = flags_reg[FLAG_C];
    assign flag_negative_o = flags_reg[FLAG_N];

    // ================================================
    // PC, ALU and control unit
    // ================================================
    program_counter #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_program_counter (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .enable_i (pc_enable),
        .load_i   (load_pc),
        .pc_i     (bus[ADDR_WIDTH-1:0]),
        .pc_o     (pc)
    );

    alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_alu (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .a_i        (a_reg),
        .b_i        (b_reg),
        .alu_op_i   (alu_op),
        .result_o   (alu_result),
        .zero_o     (alu_zero),
        .carry_o    (alu_carry),
        .negative_o (alu_negative)
    );

    control_unit u_control_unit (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .opcode_i       (opcode),
        .flags_i        (flags_reg),
        .ustep_o        (ustep),
        .load_a_o       (load_a),
        .load_b_o       (load_b),
        .load_ir_o      (load_ir),
        .load_pc_o      (load_pc),
        .load_mar_o     (load_mar),
        .load_flags_o   (load_flags),
        .load_sets_zn_o (load_sets_zn),
        .mem_write_o    (mem_write_o),
        .oe_pc_o        (oe_pc),
        .oe_ram_o       (oe_ram),
        .oe_ir_o        (oe_ir),
        .oe_alu_o       (oe_alu),
        .oe_a_o         (oe_a),
        .pc_enable_o    (pc_enable),
        .out_load_o     (out_load),
        .alu_op_o       (alu_op),
        .halt_o         (halt_o)
    );

endmodule

`default_nettype wire

//--- design/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit
    import arch_defs_pkg::*;
(
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire  opcode_e         opcode_i,
    input  wire  [FLAG_COUNT-1:0] flags_i,
    output ustep_t                ustep_o,
    // Register load strobes
    output logic                  load_a_o,
    output logic                  load_b_o,
    output logic                  load_ir_o,
    output logic                  load_pc_o,
    output logic                  load_mar_o,
    output logic                  load_flags_o,
    output logic                  load_sets_zn_o,
    output logic                  mem_write_o,
    // Bus output enables
    output logic                  oe_pc_o,
    output logic                  oe_ram_o,
    output logic                  oe_ir_o,
    output logic                  oe_alu_o,
    output logic                  oe_a_o,
    // Misc control
    output logic                  pc_enable_o,
    output logic                  out_load_o,
    output alu_op_e               alu_op_o,
    output logic                  halt_o
);

    // Set on the final microstep of an instruction
    logic last_step;
    // Condition of a conditional jump is met
    logic take_jump;

    // ================================================
    // Microstep sequencer
    // ================================================
    // Frozen for good once HLT reaches its execute step
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ustep_o <= '0;
        end else if (!halt_o) begin
            if (last_step) begin
                ustep_o <= '0;
            end else begin
                ustep_o <= ustep_o + 1'b1;
            end
        end
    end

    // Branch condition from the FLAGS register
    always_comb begin
        case (opcode_i)
            JZ:      take_jump = flags_i[FLAG_Z];
            JC:      take_jump = flags_i[FLAG_C];
            JN:      take_jump = flags_i[FLAG_N];
            default: take_jump = 1'b0;
        endcase
    end

    // ALU function follows the opcode in every step
    always_comb begin
        case (opcode_i)
            SUB:     alu_op_o = ALU_SUB;
            AND:     alu_op_o = ALU_AND;
            ORR:     alu_op_o = ALU_ORR;
            default: alu_op_o = ALU_ADD;
        endcase
    end

    // ================================================
    // Microcode table
    // ================================================
    always_comb begin
        // All strobes idle unless a step asks for them
        load_a_o       = 1'b0;
        load_b_o       = 1'b0;
        load_ir_o      = 1'b0;
        load_pc_o      = 1'b0;
        load_mar_o     = 1'b0;
        load_flags_o   = 1'b0;
        load_sets_zn_o = 1'b0;
        mem_write_o    = 1'b0;
        oe_pc_o        = 1'b0;
        oe_ram_o       = 1'b0;
        oe_ir_o        = 1'b0;
        oe_alu_o       = 1'b0;
        oe_a_o         = 1'b0;
        pc_enable_o    = 1'b0;
        out_load_o     = 1'b0;
        halt_o         = 1'b0;
        last_step      = 1'b0;

        case (ustep_o)
            // Fetch: PC to MAR
            3'd0: begin
                oe_pc_o    = 1'b1;
                load_mar_o = 1'b1;
            end
            // Fetch: RAM to IR, bump PC
            // Opcode here is the byte being fetched, so NOP can end now
            3'd1: begin
                oe_ram_o    = 1'b1;
                load_ir_o   = 1'b1;
                pc_enable_o = 1'b1;
                last_step   = (opcode_i == NOP);
            end
            // First execute step
            3'd2: begin
                case (opcode_i)
                    LDI: begin
                        oe_ir_o        = 1'b1;
                        load_a_o       = 1'b1;
                        load_flags_o   = 1'b1;
                        load_sets_zn_o = 1'b1;
                        last_step      = 1'b1;
                    end
                    // Operand address into MAR
                    LDA, LDB, STA: begin
                        oe_ir_o    = 1'b1;
                        load_mar_o = 1'b1;
                    end
                    // ALU is busy filling its result register
                    ADD, SUB, AND, ORR: ;
                    JMP: begin
                        oe_ir_o   = 1'b1;
                        load_pc_o = 1'b1;
                        last_step = 1'b1;
                    end
                    JZ, JC, JN: begin
                        oe_ir_o   = take_jump;
                        load_pc_o = take_jump;
                        last_step = 1'b1;
                    end
                    OUT: begin
                        out_load_o = 1'b1;
                        last_step  = 1'b1;
                    end
                    HLT: halt_o = 1'b1;
                    default: last_step = 1'b1;
                endcase
            end
            // Second execute step
            3'd3: begin
                last_step = 1'b1;
                case (opcode_i)
                    LDA, LDB: begin
                        oe_ram_o       = 1'b1;
                        load_a_o       = (opcode_i == LDA);
                        load_b_o       = (opcode_i == LDB);
                        load_flags_o   = 1'b1;
                        load_sets_zn_o = 1'b1;
                    end
                    STA: begin
                        oe_a_o      = 1'b1;
                        mem_write_o = 1'b1;
                    end
                    ADD, SUB, AND, ORR: begin
                        oe_alu_o     = 1'b1;
                        load_a_o     = 1'b1;
                        load_flags_o = 1'b1;
                    end
                    default: ;
                endcase
            end
            // Steps past 3 are never reached, recover to fetch
            default: last_step = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu
    import arch_defs_pkg::*;
#(
    parameter int DATA_WIDTH = arch_defs_pkg::DATA_WIDTH
) (
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire  [DATA_WIDTH-1:0] a_i,
    input  wire  [DATA_WIDTH-1:0] b_i,
    input  wire  alu_op_e         alu_op_i,
    output logic [DATA_WIDTH-1:0] result_o,
    output logic                  zero_o,
    output logic                  carry_o,
    output logic                  negative_o
);

    // One extra bit holds the carry or the borrow
    logic [DATA_WIDTH:0] calc;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: calc = {1'b0, a_i} + {1'b0, b_i};
            // Top bit set means borrow, so carry is its inverse
            ALU_SUB: calc = {1'b0, a_i} - {1'b0, b_i};
            ALU_AND: calc = {1'b0, a_i & b_i};
            default: calc = {1'b0, a_i | b_i};
        endcase
    end

    // Result and status are registered together, one cycle behind the inputs
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o   <= '0;
            zero_o     <= 1'b0;
            carry_o    <= 1'b0;
            negative_o <= 1'b0;
        end else begin
            result_o   <= calc[DATA_WIDTH-1:0];
            zero_o     <= (calc[DATA_WIDTH-1:0] == '0);
            negative_o <= calc[DATA_WIDTH-1];
            // Logic ops never produce a carry
            case (alu_op_i)
                ALU_ADD: carry_o <= calc[DATA_WIDTH];
                ALU_SUB: carry_o <= ~calc[DATA_WIDTH];
                default: carry_o <= 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/program_counter.sv
`timescale 1ns/10ps
`default_nettype none

module program_counter
    import arch_defs_pkg::*;
#(
    parameter int ADDR_WIDTH = arch_defs_pkg::ADDR_WIDTH
) (
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire                   enable_i,
    input  wire                   load_i,
    input  wire  [ADDR_WIDTH-1:0] pc_i,
    output logic [ADDR_WIDTH-1:0] pc_o
);

    // Jump target beats increment
    // Natural wrap from the top address back to 0
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o <= '0;
        end else if (load_i) begin
            pc_o <= pc_i;
        end else if (enable_i) begin
            pc_o <= pc_o + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/arch_defs_pkg.sv
`default_nettype none

package arch_defs_pkg;

    // ================================================
    // Datapath widths
    // ================================================
    // Bus, registers and RAM words
    localparam int DATA_WIDTH    = 8;
    // PC, MAR and RAM address
    localparam int ADDR_WIDTH    = 4;
    // Instruction split into upper and lower nibble
    localparam int OPCODE_WIDTH  = 4;
    localparam int OPERAND_WIDTH = 4;

    // Status flags and their bit positions in FLAGS
    localparam int FLAG_COUNT = 3;
    localparam int FLAG_Z     = 0;
    localparam int FLAG_C     = 1;
    localparam int FLAG_N     = 2;

    // ================================================
    // Instruction set
    // ================================================
    // Code 13 is unused and runs as a three-cycle no-op
    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP = 4'd0,
        LDA = 4'd1,
        LDB = 4'd2,
        LDI = 4'd3,
        STA = 4'd4,
        ADD = 4'd5,
        SUB = 4'd6,
        AND = 4'd7,
        ORR = 4'd8,
        JMP = 4'd9,
        JZ  = 4'd10,
        JC  = 4'd11,
        JN  = 4'd12,
        OUT = 4'd14,
        HLT = 4'd15
    } opcode_e;

    // ALU function select
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_ORR = 2'd3
    } alu_op_e;

    // Microstep index within one instruction
    typedef logic [2:0] ustep_t;

endpackage

`default_nettype wire
